// ==== design/npc_consts.svh ====
// npc core constants
`ifndef NPC_CONSTS_SVH
`define NPC_CONSTS_SVH

// ****************************************
// datapath and instruction widths
`define NPC_XLEN 64
`define NPC_ILEN 32

// memory depth in 64-bit words
`define NPC_MEM_WORDS 256
// word address, byte address with bits 2:0 dropped
`define NPC_MEM_AW ($clog2(`NPC_MEM_WORDS))

// ****************************************
// queue depth per stage, also the starting credit count
`define NPC_CREDITS 2
// counter holds 0 up to NPC_CREDITS
`define NPC_CREDIT_W ($clog2(`NPC_CREDITS + 1))

// first fetch address
`define NPC_RESET_PC 64'h0

`endif

// ==== design/npc_isa_pkg.sv ====
// rv64 isa subset types
`default_nettype none

package npc_isa_pkg;

	// ****************************************
	// instruction formats, msb first
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} inst_r_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} inst_i_t;

	// store immediate split around rs2/rs1
	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} inst_s_t;

	// branch offset bits scattered, bit 0 implied zero
	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		logic [6:0] opcode;
	} inst_b_t;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} inst_u_t;

	// one fetched word, read through whichever view the opcode calls for
	typedef union packed {
		inst_r_t r;
		inst_i_t i;
		inst_s_t s;
		inst_b_t b;
		inst_u_t u;
	} inst_word_u;

	// ****************************************
	// major opcodes
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LUI    = 7'b0110111,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_BRANCH = 7'b1100011,
		OPC_SYSTEM = 7'b1110011
	} opcode_e;

	// funct3 / funct7 codes
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;
	localparam logic [2:0] F3_BEQ     = 3'b000;
	localparam logic [6:0] F7_SUB     = 7'b0100000;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_PASS_B
	} alu_op_e;

endpackage

`default_nettype wire

// ==== design/npc_pipe_pkg.sv ====
// pipeline and memory payload types
`include "npc_consts.svh"
`default_nettype none

package npc_pipe_pkg;

	// ****************************************
	// fetch to decode
	typedef struct packed {
		logic [`NPC_XLEN-1:0]   pc;
		npc_isa_pkg::inst_word_u inst;
	} fetch_pkt_t;

	// decode to execute, operands already read
	typedef struct packed {
		logic [`NPC_XLEN-1:0] pc;
		npc_isa_pkg::alu_op_e alu_op;
		logic [`NPC_XLEN-1:0] a;
		logic [`NPC_XLEN-1:0] b;
		logic [`NPC_XLEN-1:0] store_data;
		logic [`NPC_XLEN-1:0] br_target;
		logic [4:0]           rd;
		logic                 reg_write;
		logic                 is_load;
		logic                 is_store;
		logic                 is_branch;
		logic                 branch_on_equal;
		logic                 is_halt;
	} exec_pkt_t;

	// ****************************************
	// memory side
	typedef struct packed {
		logic                   valid;
		logic                   write;
		logic [`NPC_MEM_AW-1:0] addr;
		logic [`NPC_XLEN-1:0]   wdata;
	} mem_req_t;

	typedef struct packed {
		logic                 valid;
		logic [`NPC_XLEN-1:0] rdata;
	} mem_rsp_t;

	// program image write, only while in reset
	typedef struct packed {
		logic                   en;
		logic [`NPC_MEM_AW-1:0] addr;
		logic [`NPC_XLEN-1:0]   data;
	} load_t;

	// ****************************************
	// completion trace and branch redirect
	typedef struct packed {
		logic                 valid;
		logic [`NPC_XLEN-1:0] pc;
		logic [4:0]           rd;
		logic [`NPC_XLEN-1:0] value;
	} retire_t;

	typedef struct packed {
		logic                 valid;
		logic [`NPC_XLEN-1:0] target;
	} redirect_t;

endpackage

`default_nettype wire

// ==== design/npc_fetch.sv ====
// instruction fetch stage
`include "npc_consts.svh"
`default_nettype none
`timescale 1ns/1ps

module npc_fetch (
	input  logic                      clk,
	input  logic                      rst,
	input  npc_pipe_pkg::redirect_t   redirect,
	input  logic                      halt,
	input  logic                      credit_return,
	output npc_pipe_pkg::mem_req_t    mem_req,
	input  npc_pipe_pkg::mem_rsp_t    mem_rsp,
	output logic                      pkt_valid,
	output npc_pipe_pkg::fetch_pkt_t  pkt
);
	localparam int CW = `NPC_CREDIT_W;

	logic [`NPC_XLEN-1:0] pc;
	logic [CW-1:0]        credits;
	// low for the first cycle out of reset
	logic                 run;
	logic                 send;

	// ****************************************
	// request side
	// at most one outstanding fetch, request dropped while its response is back
	// no new fetch in the redirect cycle, old pc is dead
	assign mem_req.valid = run && !halt && !redirect.valid && !mem_rsp.valid &&
		(credits != '0);
	assign mem_req.write = 1'b0;
	assign mem_req.addr  = pc[`NPC_MEM_AW+2:3];
	assign mem_req.wdata = '0;

	// ****************************************
	// response side
	// response landing with a redirect belongs to the old path
	assign send      = mem_rsp.valid && !redirect.valid;
	assign pkt_valid = send;
	assign pkt.pc    = pc;
	// pc bit 2 picks the upper instruction of the word
	assign pkt.inst  = pc[2] ? mem_rsp.rdata[2*`NPC_ILEN-1:`NPC_ILEN] :
		mem_rsp.rdata[`NPC_ILEN-1:0];

	always_ff @(posedge clk) begin
		if (rst) begin
			pc      <= `NPC_RESET_PC;
			credits <= CW'(`NPC_CREDITS);
			run     <= 1'b0;
		end else begin
			run <= 1'b1;
			if (redirect.valid) begin
				// decode queue flushed in the same cycle
				pc      <= redirect.target;
				credits <= CW'(`NPC_CREDITS);
			end else begin
				if (send) begin
					pc <= pc + `NPC_XLEN'(4);
				end
				credits <= credits + CW'(credit_return) - CW'(send);
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/npc_decode.sv ====
// decode stage with operand read and scoreboard
`include "npc_consts.svh"
`default_nettype none
`timescale 1ns/1ps

module npc_decode (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      flush,
	input  logic                      in_valid,
	input  npc_pipe_pkg::fetch_pkt_t  in_pkt,
	output logic                      credit_to_fetch,
	output logic [4:0]                rs1_addr,
	output logic [4:0]                rs2_addr,
	input  logic [`NPC_XLEN-1:0]      rs1_data,
	input  logic [`NPC_XLEN-1:0]      rs2_data,
	input  logic [31:0]               busy,
	output logic [4:0]                issue_rd,
	output logic                      issue_set,
	input  logic                      credit_return,
	output logic                      out_valid,
	output npc_pipe_pkg::exec_pkt_t   out_pkt
);
	import npc_isa_pkg::*;
	import npc_pipe_pkg::*;

	localparam int PW = $clog2(`NPC_CREDITS);
	localparam int CW = `NPC_CREDIT_W;

	fetch_pkt_t           q [`NPC_CREDITS];
	logic [PW-1:0]        rd_ptr;
	logic [PW-1:0]        wr_ptr;
	logic [CW-1:0]        count;
	// credits toward execute
	logic [CW-1:0]        credits;
	// set once ebreak issues
	logic                 halt_hold;
	fetch_pkt_t           head;
	inst_word_u           inst;
	logic [`NPC_XLEN-1:0] imm_i;
	logic [`NPC_XLEN-1:0] imm_s;
	logic [`NPC_XLEN-1:0] imm_b;
	logic [`NPC_XLEN-1:0] imm_u;
	logic                 uses_rs1;
	logic                 uses_rs2;
	logic                 stall;
	logic                 push;
	logic                 issue;

	// ****************************************
	// input queue
	assign push = in_valid && !flush;
	assign head = q[rd_ptr];
	assign inst = head.inst;

	// payload, no reset
	always_ff @(posedge clk) begin
		if (push) begin
			q[wr_ptr] <= in_pkt;
		end
	end

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			rd_ptr    <= '0;
			wr_ptr    <= '0;
			count     <= '0;
			credits   <= CW'(`NPC_CREDITS);
			halt_hold <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + PW'(1);
			end
			if (issue) begin
				rd_ptr <= rd_ptr + PW'(1);
			end
			count   <= count + CW'(push) - CW'(issue);
			credits <= credits + CW'(credit_return) - CW'(issue);
			// nothing younger than ebreak may issue
			if (issue && out_pkt.is_halt) begin
				halt_hold <= 1'b1;
			end
		end
	end

	// ****************************************
	// field and immediate extraction
	// rs fields sit at the same place in r, s and b
	assign rs1_addr = inst.r.rs1;
	assign rs2_addr = inst.r.rs2;
	assign imm_i = {{(`NPC_XLEN-12){inst.i.imm[11]}}, inst.i.imm};
	assign imm_s = {{(`NPC_XLEN-12){inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
	assign imm_b = {{(`NPC_XLEN-13){inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
		inst.b.imm10_5, inst.b.imm4_1, 1'b0};
	assign imm_u = {{(`NPC_XLEN-32){inst.u.imm[19]}}, inst.u.imm, 12'b0};

	always_comb begin
		out_pkt            = '0;
		out_pkt.pc         = head.pc;
		out_pkt.alu_op     = ALU_ADD;
		out_pkt.a          = rs1_data;
		out_pkt.b          = imm_i;
		out_pkt.store_data = rs2_data;
		out_pkt.br_target  = head.pc + imm_b;
		out_pkt.rd         = inst.r.rd;
		uses_rs1           = 1'b0;
		uses_rs2           = 1'b0;
		case (inst.r.opcode)
			OPC_OP: begin
				uses_rs1          = 1'b1;
				uses_rs2          = 1'b1;
				out_pkt.b         = rs2_data;
				out_pkt.reg_write = 1'b1;
				case (inst.r.funct3)
					F3_ADD_SUB: out_pkt.alu_op = (inst.r.funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
					F3_XOR:     out_pkt.alu_op = ALU_XOR;
					F3_OR:      out_pkt.alu_op = ALU_OR;
					F3_AND:     out_pkt.alu_op = ALU_AND;
					default:    out_pkt.alu_op = ALU_ADD;
				endcase
			end
			// addi only
			OPC_OP_IMM: begin
				uses_rs1          = 1'b1;
				out_pkt.reg_write = 1'b1;
			end
			OPC_LUI: begin
				out_pkt.alu_op    = ALU_PASS_B;
				out_pkt.b         = imm_u;
				out_pkt.reg_write = 1'b1;
			end
			// ld, address is rs1 + imm
			OPC_LOAD: begin
				uses_rs1          = 1'b1;
				out_pkt.is_load   = 1'b1;
				out_pkt.reg_write = 1'b1;
			end
			OPC_STORE: begin
				uses_rs1         = 1'b1;
				uses_rs2         = 1'b1;
				out_pkt.b        = imm_s;
				out_pkt.is_store = 1'b1;
			end
			// beq / bne, compared in execute
			OPC_BRANCH: begin
				uses_rs1                = 1'b1;
				uses_rs2                = 1'b1;
				out_pkt.b               = rs2_data;
				out_pkt.is_branch       = 1'b1;
				out_pkt.branch_on_equal = (inst.b.funct3 == F3_BEQ);
			end
			OPC_SYSTEM: out_pkt.is_halt = 1'b1;
			default: ;
		endcase
	end

	// ****************************************
	// scoreboard stall and issue
	// own rd busy too, keeps writes in order
	assign stall = (uses_rs1 && busy[rs1_addr]) || (uses_rs2 && busy[rs2_addr]) ||
		(out_pkt.reg_write && busy[out_pkt.rd]);
	assign issue = (count != '0) && !stall && (credits != '0) && !halt_hold && !flush;

	assign out_valid       = issue;
	assign credit_to_fetch = issue;
	assign issue_set       = issue && out_pkt.reg_write;
	assign issue_rd        = out_pkt.rd;

endmodule

`default_nettype wire

// ==== design/npc_execute.sv ====
// execute, memory access and retire
`include "npc_consts.svh"
`default_nettype none
`timescale 1ns/1ps

module npc_execute (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      in_valid,
	input  npc_pipe_pkg::exec_pkt_t   in_pkt,
	output logic                      credit_to_decode,
	output npc_pipe_pkg::mem_req_t    mem_req,
	input  npc_pipe_pkg::mem_rsp_t    mem_rsp,
	output logic                      wr_en,
	output logic [4:0]                wr_addr,
	output logic [`NPC_XLEN-1:0]      wr_data,
	output npc_pipe_pkg::redirect_t   redirect,
	output logic                      halt,
	output npc_pipe_pkg::retire_t     retire
);
	import npc_isa_pkg::*;
	import npc_pipe_pkg::*;

	localparam int PW = $clog2(`NPC_CREDITS);
	localparam int CW = `NPC_CREDIT_W;

	exec_pkt_t            q [`NPC_CREDITS];
	logic [PW-1:0]        rd_ptr;
	logic [PW-1:0]        wr_ptr;
	logic [CW-1:0]        count;
	// instruction in flight
	exec_pkt_t            cur;
	logic                 cur_valid;
	logic                 mem_done;
	logic [`NPC_XLEN-1:0] ld_data;
	logic                 halt_q;
	logic                 is_mem;
	logic                 done;
	logic                 taken;
	logic                 push;
	logic                 pop;
	logic [`NPC_XLEN-1:0] alu_res;
	logic [`NPC_XLEN-1:0] result;

	// ****************************************
	// alu and branch compare
	always_comb begin
		case (cur.alu_op)
			ALU_ADD:    alu_res = cur.a + cur.b;
			ALU_SUB:    alu_res = cur.a - cur.b;
			ALU_AND:    alu_res = cur.a & cur.b;
			ALU_OR:     alu_res = cur.a | cur.b;
			ALU_XOR:    alu_res = cur.a ^ cur.b;
			ALU_PASS_B: alu_res = cur.b;
			default:    alu_res = cur.a + cur.b;
		endcase
	end

	assign taken  = cur.is_branch && ((cur.a == cur.b) == cur.branch_on_equal);
	assign is_mem = cur.is_load || cur.is_store;
	// alu ops finish at once, ld/sd one cycle after the response
	assign done   = cur_valid && (!is_mem || mem_done);
	assign result = cur.is_load ? ld_data : alu_res;

	// ****************************************
	// queue and sequencing
	assign push = in_valid && !redirect.valid;
	// next entry enters as the current one retires
	assign pop  = (count != '0) && (!cur_valid || done) && !redirect.valid;

	always_ff @(posedge clk) begin
		if (push) begin
			q[wr_ptr] <= in_pkt;
		end
		if (pop) begin
			cur <= q[rd_ptr];
		end
		if (mem_rsp.valid) begin
			ld_data <= mem_rsp.rdata;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_ptr    <= '0;
			wr_ptr    <= '0;
			count     <= '0;
			cur_valid <= 1'b0;
			mem_done  <= 1'b0;
			halt_q    <= 1'b0;
		end else begin
			if (redirect.valid) begin
				// wrong-path entries dropped
				rd_ptr <= '0;
				wr_ptr <= '0;
				count  <= '0;
			end else begin
				if (push) begin
					wr_ptr <= wr_ptr + PW'(1);
				end
				if (pop) begin
					rd_ptr <= rd_ptr + PW'(1);
				end
				count <= count + CW'(push) - CW'(pop);
			end
			if (pop) begin
				cur_valid <= 1'b1;
			end else if (done) begin
				cur_valid <= 1'b0;
			end
			if (done) begin
				mem_done <= 1'b0;
			end else if (cur_valid && is_mem && mem_rsp.valid) begin
				mem_done <= 1'b1;
			end
			// sticky until reset
			if (done && cur.is_halt) begin
				halt_q <= 1'b1;
			end
		end
	end

	// ****************************************
	// memory request, held until granted
	assign mem_req.valid = cur_valid && is_mem && !mem_done && !mem_rsp.valid;
	assign mem_req.write = cur.is_store;
	assign mem_req.addr  = alu_res[`NPC_MEM_AW+2:3];
	assign mem_req.wdata = cur.store_data;

	// ****************************************
	// writeback, redirect, retire
	assign wr_en   = done && cur.reg_write;
	assign wr_addr = cur.rd;
	assign wr_data = result;

	assign redirect.valid  = done && taken;
	assign redirect.target = cur.br_target;

	assign credit_to_decode = pop;
	assign halt             = halt_q;

	// stores, branches and ebreak report rd 0, value 0
	assign retire.valid = done;
	assign retire.pc    = cur.pc;
	assign retire.rd    = cur.reg_write ? cur.rd : 5'd0;
	assign retire.value = cur.reg_write ? result : '0;

endmodule

`default_nettype wire

// ==== design/npc_regfile.sv ====
// register file and busy scoreboard
`include "npc_consts.svh"
`default_nettype none
`timescale 1ns/1ps

module npc_regfile (
	input  logic                 clk,
	input  logic                 rst,
	input  logic [4:0]           rs1_addr,
	input  logic [4:0]           rs2_addr,
	output logic [`NPC_XLEN-1:0] rs1_data,
	output logic [`NPC_XLEN-1:0] rs2_data,
	input  logic                 wr_en,
	input  logic [4:0]           wr_addr,
	input  logic [`NPC_XLEN-1:0] wr_data,
	input  logic [4:0]           issue_rd,
	input  logic                 issue_set,
	input  logic                 flush,
	output logic [31:0]          busy
);
	// x1..x31, x0 has no storage
	logic [`NPC_XLEN-1:0] regs [1:31];

	// ****************************************
	// storage
	always_ff @(posedge clk) begin
		if (wr_en && (wr_addr != 5'd0)) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// no bypass, new value visible the cycle after the write
	assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
	assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

	// ****************************************
	// scoreboard
	// flush only comes with a branch, which owns no rd
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			busy <= '0;
		end else begin
			if (wr_en) begin
				busy[wr_addr] <= 1'b0;
			end
			// younger issue overrides a same-cycle clear
			if (issue_set && (issue_rd != 5'd0)) begin
				busy[issue_rd] <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/npc_mem_arbiter.sv ====
// memory array with data-first arbiter
`include "npc_consts.svh"
`default_nettype none
`timescale 1ns/1ps

module npc_mem_arbiter (
	input  logic                   clk,
	input  logic                   rst,
	input  npc_pipe_pkg::load_t    load,
	input  npc_pipe_pkg::mem_req_t data_req,
	output npc_pipe_pkg::mem_rsp_t data_rsp,
	input  npc_pipe_pkg::mem_req_t inst_req,
	output npc_pipe_pkg::mem_rsp_t inst_rsp
);
	import npc_pipe_pkg::*;

	logic [`NPC_XLEN-1:0] mem [`NPC_MEM_WORDS];
	logic                 grant_data;
	logic                 grant_inst;
	mem_req_t             sel;
	logic [`NPC_XLEN-1:0] rdata_q;
	logic                 data_vld_q;
	logic                 inst_vld_q;

	// ****************************************
	// grant, data side first
	assign grant_data = data_req.valid;
	assign grant_inst = inst_req.valid && !data_req.valid;
	assign sel        = grant_data ? data_req : inst_req;

	// ****************************************
	// array
	// program image goes in while rst is high, stages wait
	always_ff @(posedge clk) begin
		if (rst) begin
			if (load.en) begin
				mem[load.addr] <= load.data;
			end
		end else if (grant_data && data_req.write) begin
			mem[data_req.addr] <= data_req.wdata;
		end
	end

	// one read port shared by both sides
	always_ff @(posedge clk) begin
		if (grant_data || grant_inst) begin
			rdata_q <= mem[sel.addr];
		end
	end

	// response one cycle after grant, only to the granted side
	always_ff @(posedge clk) begin
		if (rst) begin
			data_vld_q <= 1'b0;
			inst_vld_q <= 1'b0;
		end else begin
			data_vld_q <= grant_data;
			inst_vld_q <= grant_inst;
		end
	end

	// stores get a valid too, marks the write done
	assign data_rsp.valid = data_vld_q;
	assign data_rsp.rdata = rdata_q;
	assign inst_rsp.valid = inst_vld_q;
	assign inst_rsp.rdata = rdata_q;

endmodule

`default_nettype wire

// ==== design/npc_core.sv ====
// npc core top level
`include "npc_consts.svh"
`default_nettype none
`timescale 1ns/1ps

module npc_core (
	input  logic                  clk,
	input  logic                  rst,
	input  npc_pipe_pkg::load_t   load,
	output npc_pipe_pkg::retire_t retire,
	output logic                  halted
);
	import npc_pipe_pkg::*;

	// ****************************************
	// stage links
	logic       fd_valid;
	fetch_pkt_t fd_pkt;
	logic       fd_credit;
	logic       dx_valid;
	exec_pkt_t  dx_pkt;
	logic       dx_credit;
	redirect_t  redirect;

	// memory ports
	mem_req_t inst_req;
	mem_rsp_t inst_rsp;
	mem_req_t data_req;
	mem_rsp_t data_rsp;

	// register file ports
	logic [4:0]           rs1_addr;
	logic [4:0]           rs2_addr;
	logic [`NPC_XLEN-1:0] rs1_data;
	logic [`NPC_XLEN-1:0] rs2_data;
	logic [31:0]          busy;
	logic [4:0]           issue_rd;
	logic                 issue_set;
	logic                 wr_en;
	logic [4:0]           wr_addr;
	logic [`NPC_XLEN-1:0] wr_data;

	// ****************************************
	// pipeline
	npc_fetch u_fetch (
		.clk           (clk),
		.rst           (rst),
		.redirect      (redirect),
		.halt          (halted),
		.credit_return (fd_credit),
		.mem_req       (inst_req),
		.mem_rsp       (inst_rsp),
		.pkt_valid     (fd_valid),
		.pkt           (fd_pkt)
	);

	npc_decode u_decode (
		.clk             (clk),
		.rst             (rst),
		.flush           (redirect.valid),
		.in_valid        (fd_valid),
		.in_pkt          (fd_pkt),
		.credit_to_fetch (fd_credit),
		.rs1_addr        (rs1_addr),
		.rs2_addr        (rs2_addr),
		.rs1_data        (rs1_data),
		.rs2_data        (rs2_data),
		.busy            (busy),
		.issue_rd        (issue_rd),
		.issue_set       (issue_set),
		.credit_return   (dx_credit),
		.out_valid       (dx_valid),
		.out_pkt         (dx_pkt)
	);

	npc_execute u_execute (
		.clk              (clk),
		.rst              (rst),
		.in_valid         (dx_valid),
		.in_pkt           (dx_pkt),
		.credit_to_decode (dx_credit),
		.mem_req          (data_req),
		.mem_rsp          (data_rsp),
		.wr_en            (wr_en),
		.wr_addr          (wr_addr),
		.wr_data          (wr_data),
		.redirect         (redirect),
		.halt             (halted),
		.retire           (retire)
	);

	// ****************************************
	// shared resources
	npc_regfile u_regfile (
		.clk       (clk),
		.rst       (rst),
		.rs1_addr  (rs1_addr),
		.rs2_addr  (rs2_addr),
		.rs1_data  (rs1_data),
		.rs2_data  (rs2_data),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.issue_rd  (issue_rd),
		.issue_set (issue_set),
		.flush     (redirect.valid),
		.busy      (busy)
	);

	npc_mem_arbiter u_mem (
		.clk      (clk),
		.rst      (rst),
		.load     (load),
		.data_req (data_req),
		.data_rsp (data_rsp),
		.inst_req (inst_req),
		.inst_rsp (inst_rsp)
	);

endmodule

`default_nettype wire

// ==== verification/npc_core_chk.sv ====
// bound pipeline protocol checks
`include "npc_consts.svh"
`default_nettype none
`timescale 1ns/1ps

module npc_core_chk (
	input logic                     clk,
	input logic                     rst,
	input logic [`NPC_CREDIT_W-1:0] fetch_credits,
	input logic [`NPC_CREDIT_W-1:0] decode_credits,
	input logic [`NPC_CREDIT_W-1:0] exec_count,
	input logic                     fd_valid,
	input logic                     dx_valid,
	input logic                     inst_req_valid,
	input logic [`NPC_MEM_AW-1:0]   inst_req_addr,
	input logic                     data_req_valid,
	input logic                     wr_en,
	input logic [4:0]               wr_addr,
	input logic [31:0]              busy
);
	// ****************************************
	// credit links
	// counters never above queue depth
	a_fetch_credit_max: assert property (@(posedge clk) disable iff (rst)
		fetch_credits <= `NPC_CREDITS)
		else $error("fetch credit counter above queue depth");

	a_decode_credit_max: assert property (@(posedge clk) disable iff (rst)
		decode_credits <= `NPC_CREDITS)
		else $error("decode credit counter above queue depth");

	// a send always spends a credit that exists
	a_fetch_send: assert property (@(posedge clk) disable iff (rst)
		fd_valid |-> (fetch_credits != '0))
		else $error("fetch sent a packet with no credit");

	// a send never lands in a full receiver queue
	a_exec_room: assert property (@(posedge clk) disable iff (rst)
		dx_valid |-> (exec_count < `NPC_CREDITS))
		else $error("decode sent a packet into a full execute queue");

	// ****************************************
	// arbiter and scoreboard
	// losing fetch request waits unchanged behind data
	a_inst_hold: assert property (@(posedge clk) disable iff (rst)
		(inst_req_valid && data_req_valid) |=> (inst_req_valid && $stable(inst_req_addr)))
		else $error("fetch request changed while waiting for the grant");

	// every register write belongs to an instruction that set busy
	a_write_busy: assert property (@(posedge clk) disable iff (rst)
		(wr_en && (wr_addr != 5'd0)) |-> busy[wr_addr])
		else $error("register written while its busy bit was clear");

endmodule

`default_nettype wire

// ==== verification/npc_core_tb.sv ====
// npc core testbench
`include "npc_consts.svh"
`default_nettype none
`timescale 1ns/1ps

module npc_core_tb;
	import npc_pipe_pkg::*;

	// ****************************************
	// table sizes and run limits
	localparam int N_WORDS      = 14;
	localparam int N_EXP        = 21;
	localparam int RESET_CYCLES = (N_WORDS > 5) ? N_WORDS : 5;
	localparam int SETTLE       = 20;
	localparam int WATCHDOG     = N_EXP * 40 + RESET_CYCLES;

	// major opcodes and function codes of the rv64i encoding
	localparam logic [6:0] OP_REG    = 7'b0110011;
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [2:0] F3_ADD    = 3'b000;
	localparam logic [2:0] F3_XOR    = 3'b100;
	localparam logic [2:0] F3_OR     = 3'b110;
	localparam logic [2:0] F3_AND    = 3'b111;
	localparam logic [2:0] F3_D      = 3'b011;
	localparam logic [2:0] F3_BEQ    = 3'b000;
	localparam logic [2:0] F3_BNE    = 3'b001;
	localparam logic [6:0] F7_SUB    = 7'b0100000;
	localparam logic [31:0] EBREAK   = 32'h0010_0073;

	// one memory word with lo at pc and hi at pc + 4
	typedef struct packed {
		logic [`NPC_MEM_AW-1:0] addr;
		logic [31:0]            lo;
		logic [31:0]            hi;
	} prog_row_t;

	typedef struct packed {
		logic [`NPC_XLEN-1:0] pc;
		logic [4:0]           rd;
		logic [`NPC_XLEN-1:0] value;
	} golden_t;

	logic      clk;
	logic      rst;
	load_t     load;
	retire_t   retire;
	logic      halted;
	prog_row_t prog_tab [N_WORDS];
	golden_t   retire_tab [N_EXP];
	int        errors = 0;
	int        n_retired = 0;

	npc_core u_dut (
		.clk    (clk),
		.rst    (rst),
		.load   (load),
		.retire (retire),
		.halted (halted)
	);

	bind npc_core npc_core_chk u_chk (
		.clk            (clk),
		.rst            (rst),
		.fetch_credits  (u_fetch.credits),
		.decode_credits (u_decode.credits),
		.exec_count     (u_execute.count),
		.fd_valid       (fd_valid),
		.dx_valid       (dx_valid),
		.inst_req_valid (inst_req.valid),
		.inst_req_addr  (inst_req.addr),
		.data_req_valid (data_req.valid),
		.wr_en          (wr_en),
		.wr_addr        (wr_addr),
		.busy           (busy)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ****************************************
	// instruction encoders
	function automatic logic [31:0] r_form(input logic [6:0] f7, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, OP_REG};
	endfunction

	function automatic logic [31:0] i_form(input logic [6:0] opc, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] s_form(input logic [4:0] rs1, input logic [4:0] rs2,
		input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, F3_D, imm[4:0], OP_STORE};
	endfunction

	// branch offset in bytes with bit 0 dropped
	function automatic logic [31:0] b_form(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [12:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
	endfunction

	function automatic logic [31:0] u_form(input logic [4:0] rd, input logic [19:0] imm);
		return {imm, rd, OP_LUI};
	endfunction

	// ****************************************
	// program image and golden retire trace
	task automatic fill_tables();
		prog_tab[0]  = '{8'd0, i_form(OP_IMM, F3_ADD, 5'd1, 5'd0, 12'd5),
			i_form(OP_IMM, F3_ADD, 5'd2, 5'd0, 12'd3)};
		prog_tab[1]  = '{8'd1, r_form(7'd0, F3_ADD, 5'd3, 5'd1, 5'd2),
			r_form(F7_SUB, F3_ADD, 5'd4, 5'd2, 5'd1)};
		prog_tab[2]  = '{8'd2, r_form(7'd0, F3_AND, 5'd5, 5'd1, 5'd2),
			r_form(7'd0, F3_OR, 5'd6, 5'd1, 5'd2)};
		prog_tab[3]  = '{8'd3, r_form(7'd0, F3_XOR, 5'd7, 5'd1, 5'd2),
			u_form(5'd8, 20'h12345)};
		// write to x0 then read it back
		prog_tab[4]  = '{8'd4, i_form(OP_IMM, F3_ADD, 5'd0, 5'd1, 12'd7),
			r_form(7'd0, F3_ADD, 5'd9, 5'd0, 5'd1)};
		// dependent chain through x9, x10, x11
		prog_tab[5]  = '{8'd5, i_form(OP_IMM, F3_ADD, 5'd10, 5'd9, 12'd1),
			i_form(OP_IMM, F3_ADD, 5'd10, 5'd10, 12'd1)};
		prog_tab[6]  = '{8'd6, r_form(7'd0, F3_ADD, 5'd11, 5'd10, 5'd10),
			i_form(OP_IMM, F3_ADD, 5'd12, 5'd0, 12'h200)};
		// sd then ld at byte 0x208 which is word 65
		prog_tab[7]  = '{8'd7, s_form(5'd12, 5'd11, 12'd8),
			i_form(OP_LOAD, F3_D, 5'd13, 5'd12, 12'd8)};
		// taken beq then a skipped slot
		prog_tab[8]  = '{8'd8, b_form(F3_BEQ, 5'd13, 5'd11, 13'd8),
			i_form(OP_IMM, F3_ADD, 5'd14, 5'd0, 12'd99)};
		// taken bne then a skipped slot
		prog_tab[9]  = '{8'd9, b_form(F3_BNE, 5'd1, 5'd2, 13'd8),
			i_form(OP_IMM, F3_ADD, 5'd14, 5'd0, 12'd98)};
		// untaken bne falls through
		prog_tab[10] = '{8'd10, b_form(F3_BNE, 5'd1, 5'd1, 13'd8),
			i_form(OP_IMM, F3_ADD, 5'd15, 5'd13, 12'd1)};
		prog_tab[11] = '{8'd11, EBREAK, i_form(OP_IMM, F3_ADD, 5'd16, 5'd0, 12'd1)};
		// fetched past ebreak but never retires
		prog_tab[12] = '{8'd12, i_form(OP_IMM, F3_ADD, 5'd17, 5'd0, 12'd2),
			i_form(OP_IMM, F3_ADD, 5'd17, 5'd0, 12'd2)};
		// stale data under the store target
		prog_tab[13] = '{8'd65, 32'hdead_beef, 32'h0bad_f00d};

		retire_tab[0]  = '{64'h00, 5'd1, 64'd5};
		retire_tab[1]  = '{64'h04, 5'd2, 64'd3};
		retire_tab[2]  = '{64'h08, 5'd3, 64'd8};
		retire_tab[3]  = '{64'h0c, 5'd4, 64'hffff_ffff_ffff_fffe};
		retire_tab[4]  = '{64'h10, 5'd5, 64'd1};
		retire_tab[5]  = '{64'h14, 5'd6, 64'd7};
		retire_tab[6]  = '{64'h18, 5'd7, 64'd6};
		retire_tab[7]  = '{64'h1c, 5'd8, 64'h1234_5000};
		retire_tab[8]  = '{64'h20, 5'd0, 64'd12};
		retire_tab[9]  = '{64'h24, 5'd9, 64'd5};
		retire_tab[10] = '{64'h28, 5'd10, 64'd6};
		retire_tab[11] = '{64'h2c, 5'd10, 64'd7};
		retire_tab[12] = '{64'h30, 5'd11, 64'd14};
		retire_tab[13] = '{64'h34, 5'd12, 64'd512};
		retire_tab[14] = '{64'h38, 5'd0, 64'd0};
		retire_tab[15] = '{64'h3c, 5'd13, 64'd14};
		retire_tab[16] = '{64'h40, 5'd0, 64'd0};
		retire_tab[17] = '{64'h48, 5'd0, 64'd0};
		retire_tab[18] = '{64'h50, 5'd0, 64'd0};
		retire_tab[19] = '{64'h54, 5'd15, 64'd15};
		retire_tab[20] = '{64'h58, 5'd0, 64'd0};
	endtask

	// ****************************************
	// reset with program load of one word per cycle
	task automatic load_program();
		int i;
		for (i = 0; i < RESET_CYCLES; i++) begin
			@(negedge clk);
			if (i < N_WORDS) begin
				load.en   = 1'b1;
				load.addr = prog_tab[i].addr;
				load.data = {prog_tab[i].hi, prog_tab[i].lo};
			end else begin
				load = '0;
			end
		end
		@(negedge clk);
		load = '0;
		rst  = 1'b0;
	endtask

	task automatic compare_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		assert (actual === expected) else begin
			errors++;
			$display("mismatch at %0t: %s expected %h, got %h", $time, name, expected,
				actual);
		end
	endtask

	task automatic check_retire();
		assert (!halted) else begin
			errors++;
			$display("instruction at pc %h retired after the core halted", retire.pc);
		end
		assert (n_retired < N_EXP) else begin
			errors++;
			$display("more instructions retired than the program allows");
		end
		if (n_retired < N_EXP) begin
			compare_value("retire.pc", retire_tab[n_retired].pc, retire.pc);
			compare_value("retire.rd", 64'(retire_tab[n_retired].rd), 64'(retire.rd));
			compare_value("retire.value", retire_tab[n_retired].value, retire.value);
		end
		n_retired++;
	endtask

	// retire trace sampled mid-cycle
	initial begin
		forever begin
			@(negedge clk);
			if (!rst && retire.valid) begin
				check_retire();
			end
		end
	end

	initial begin
		repeat (WATCHDOG) @(posedge clk);
		$display("timeout: core did not halt within %0d cycles", WATCHDOG);
		$display("errors: %0d, retired: %0d of %0d", errors, n_retired, N_EXP);
		$display("Verification failed");
		$finish;
	end

	initial begin
		rst  = 1'b1;
		load = '0;
		fill_tables();
		load_program();
		while (!halted) begin
			@(negedge clk);
		end
		// quiet window after halt
		repeat (SETTLE) @(negedge clk);
		assert (n_retired == N_EXP) else begin
			errors++;
			$display("wrong number of retired instructions, expected %0d, got %0d",
				N_EXP, n_retired);
		end
		$display("errors: %0d, retired: %0d of %0d", errors, n_retired, N_EXP);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== npc_core.f ====
+incdir+design
design/npc_isa_pkg.sv
design/npc_pipe_pkg.sv
design/npc_fetch.sv
design/npc_decode.sv
design/npc_execute.sv
design/npc_regfile.sv
design/npc_mem_arbiter.sv
design/npc_core.sv
verification/npc_core_chk.sv
verification/npc_core_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      = npc_core_tb
FILELIST = npc_core.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	! grep -q "Verification failed" $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
